/* hdl/isaPkg.sv */
`default_nettype none

package isaPkg;

    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opAddi    = 6'b001000,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111,
        opLw      = 6'b100011,
        opSw      = 6'b101011
    } opcodeE;

    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnJr   = 6'b001000,
        fnAdd  = 6'b100000,
        fnSub  = 6'b100010,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } functE;

    typedef struct packed {
        opcodeE      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        functE       funct;
    } rTypeT;

    typedef struct packed {
        opcodeE      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iTypeT;

    typedef struct packed {
        opcodeE      opcode;
        logic [25:0] target26;
    } jTypeT;

    // one fetched word, viewed per format.
    typedef union packed {
        rTypeT r;
        iTypeT i;
        jTypeT j;
    } instrU;

    typedef enum logic [2:0] {
        aluAdd  = 3'b000,
        aluSub  = 3'b001,
        aluAnd  = 3'b010,
        aluOr   = 3'b011,
        aluXor  = 3'b100,
        aluSll  = 3'b101,
        aluSlt  = 3'b110,
        aluSltu = 3'b111
    } aluOpE;

    typedef enum logic [1:0] {
        wbAlu   = 2'b00,
        wbMem   = 2'b01,
        wbUpper = 2'b10,
        wbLink  = 2'b11 // pc+4 for jal.
    } wbSelE;

    typedef enum logic [1:0] {
        extZero  = 2'b00,
        extSign  = 2'b01,
        extUpper = 2'b10
    } extE;

    typedef struct packed {
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  wAddr;
        logic [4:0]  shamt;
        logic [31:0] imm;
        aluOpE       aluOp;
        logic        aluSrcImm;
        logic        regWrite;
        wbSelE       wbSel;
        logic        memRead;
        logic        memWrite;
        logic        branchEq;
        logic        branchNe;
        logic        jump;
        logic        jumpReg;
        logic [25:0] target26;
    } ctrlT;

endpackage

`default_nettype wire

/* hdl/wbPkg.sv */
`default_nettype none

package wbPkg;

    // master to slave.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] datW;
    } wbReqT;

    // slave to master.
    typedef struct packed {
        logic        ack;
        logic [31:0] datR;
    } wbRspT;

endpackage

`default_nettype wire

/* hdl/controller.sv */
`timescale 1ns/1ns
`default_nettype none

module controller (
    input  wire isaPkg::instrU instr,
    output isaPkg::ctrlT       ctrl
);

    isaPkg::extE ext;

    always_comb begin
        ctrl          = '0;
        ext           = isaPkg::extZero;
        ctrl.rs       = instr.r.rs;
        ctrl.rt       = instr.r.rt;
        ctrl.shamt    = instr.r.shamt;
        ctrl.target26 = instr.j.target26;
        ctrl.aluOp    = isaPkg::aluAdd;
        ctrl.wbSel    = isaPkg::wbAlu;

        case (instr.r.opcode)
            isaPkg::opSpecial: begin
                ctrl.wAddr    = instr.r.rd;
                ctrl.regWrite = 1'b1;
                case (instr.r.funct)
                    isaPkg::fnAdd:  ctrl.aluOp = isaPkg::aluAdd;
                    isaPkg::fnSub:  ctrl.aluOp = isaPkg::aluSub;
                    isaPkg::fnAnd:  ctrl.aluOp = isaPkg::aluAnd;
                    isaPkg::fnOr:   ctrl.aluOp = isaPkg::aluOr;
                    isaPkg::fnXor:  ctrl.aluOp = isaPkg::aluXor;
                    isaPkg::fnSll:  ctrl.aluOp = isaPkg::aluSll;
                    isaPkg::fnSlt:  ctrl.aluOp = isaPkg::aluSlt;
                    isaPkg::fnSltu: ctrl.aluOp = isaPkg::aluSltu;
                    isaPkg::fnJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.jumpReg  = 1'b1;
                    end
                    default: ctrl.regWrite = 1'b0; // unknown funct is a nop.
                endcase
            end
            isaPkg::opAddi, isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori: begin
                ctrl.wAddr     = instr.i.rt;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                case (instr.i.opcode)
                    isaPkg::opAndi: ctrl.aluOp = isaPkg::aluAnd;
                    isaPkg::opOri:  ctrl.aluOp = isaPkg::aluOr;
                    isaPkg::opXori: ctrl.aluOp = isaPkg::aluXor;
                    default: begin
                        ctrl.aluOp = isaPkg::aluAdd;
                        ext        = isaPkg::extSign;
                    end
                endcase
            end
            isaPkg::opLui: begin
                ext           = isaPkg::extUpper;
                ctrl.wAddr    = instr.i.rt;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = isaPkg::wbUpper;
            end
            isaPkg::opLw: begin
                ext            = isaPkg::extSign;
                ctrl.wAddr     = instr.i.rt;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.wbSel     = isaPkg::wbMem;
            end
            isaPkg::opSw: begin
                ext            = isaPkg::extSign;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            isaPkg::opBeq, isaPkg::opBne: begin
                ext           = isaPkg::extSign; // branch offsets are signed too.
                ctrl.aluOp    = isaPkg::aluSub;
                ctrl.branchEq = (instr.i.opcode == isaPkg::opBeq);
                ctrl.branchNe = (instr.i.opcode == isaPkg::opBne);
            end
            isaPkg::opJ: ctrl.jump = 1'b1;
            isaPkg::opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.wAddr    = 5'd31;
                ctrl.wbSel    = isaPkg::wbLink;
            end
            default: ; // undefined opcode, nothing happens.
        endcase

        case (ext)
            isaPkg::extSign:  ctrl.imm = {{16{instr.i.imm16[15]}}, instr.i.imm16};
            isaPkg::extUpper: ctrl.imm = {instr.i.imm16, 16'h0000};
            default:          ctrl.imm = {16'h0000, instr.i.imm16};
        endcase
    end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire logic [31:0]   a,
    input  wire logic [31:0]   b,
    input  wire logic [4:0]    shamt,
    input  wire isaPkg::aluOpE op,
    output logic [31:0]        result,
    output logic               zero
);

    always_comb begin
        case (op)
            isaPkg::aluAdd:  result = a + b;
            isaPkg::aluSub:  result = a - b;
            isaPkg::aluAnd:  result = a & b;
            isaPkg::aluOr:   result = a | b;
            isaPkg::aluXor:  result = a ^ b;
            isaPkg::aluSll:  result = b << shamt; // shifts rt, not rs.
            isaPkg::aluSlt:  result = {31'b0, ($signed(a) < $signed(b))};
            isaPkg::aluSltu: result = {31'b0, (a < b)};
            default:         result = a + b;
        endcase
    end

    // beq and bne compare via sub.
    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [4:0]  rAddrA,
    input  wire logic [4:0]  rAddrB,
    output logic [31:0]      rDataA,
    output logic [31:0]      rDataB,
    input  wire logic        wEn,
    input  wire logic [4:0]  wAddr,
    input  wire logic [31:0] wData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wEn && (wAddr != 5'd0)) begin
            regs[wAddr] <= wData;
        end
    end

    // $zero reads as zero regardless of contents.
    assign rDataA = (rAddrA == 5'd0) ? 32'd0 : regs[rAddrA];
    assign rDataB = (rAddrB == 5'd0) ? 32'd0 : regs[rAddrB];

endmodule

`default_nettype wire

/* hdl/mipsCore.sv */
`timescale 1ns/1ns
`default_nettype none

module mipsCore #(
    parameter logic [31:0] resetAddr = 32'h0000_0000
) (
    input  wire logic          clk,
    input  wire logic          reset,
    output wbPkg::wbReqT       wbReq,
    input  wire wbPkg::wbRspT  wbRsp
);

    typedef enum logic [1:0] {
        stFetch     = 2'b00,
        stExecute   = 2'b01,
        stMemory    = 2'b10,
        stWriteBack = 2'b11
    } stateE;

    stateE         state;
    logic [31:0]   pc;
    isaPkg::instrU instrReg;
    logic [31:0]   aluOut;
    logic [31:0]   loadData;

    logic          busCyc;
    logic          busWe;
    logic [31:0]   busAdr;
    logic [31:0]   busDatW;
    logic          busStart;
    logic          busDone;

    isaPkg::ctrlT  ctrl;
    logic [31:0]   rDataA;
    logic [31:0]   rDataB;
    logic [31:0]   aluB;
    logic [31:0]   aluResult;
    logic          aluZero;
    logic          regWen;
    logic [31:0]   wData;

    logic [31:0]   pcPlus4;
    logic [31:0]   branchTarget;
    logic [31:0]   jumpTarget;
    logic          taken;
    logic [31:0]   nextPc;

    controller i_controller (
        .instr (instrReg),
        .ctrl  (ctrl)
    );

    regFile i_regFile (
        .clk    (clk),
        .reset  (reset),
        .rAddrA (ctrl.rs),
        .rAddrB (ctrl.rt),
        .rDataA (rDataA),
        .rDataB (rDataB),
        .wEn    (regWen),
        .wAddr  (ctrl.wAddr),
        .wData  (wData)
    );

    assign aluB = ctrl.aluSrcImm ? ctrl.imm : rDataB;

    alu i_alu (
        .a      (rDataA),
        .b      (aluB),
        .shamt  (ctrl.shamt),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    // next pc.
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {ctrl.imm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], ctrl.target26, 2'b00};
    assign taken        = (ctrl.branchEq && aluZero) || (ctrl.branchNe && !aluZero);

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = rDataA;
        end else if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (taken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_comb begin
        case (ctrl.wbSel)
            isaPkg::wbMem:   wData = loadData;
            isaPkg::wbUpper: wData = ctrl.imm;
            isaPkg::wbLink:  wData = pcPlus4;
            default:         wData = aluOut;
        endcase
    end

    assign regWen = (state == stWriteBack) && ctrl.regWrite;

    // a bus phase opens with cyc low and closes on ack.
    assign busStart = ((state == stFetch) || (state == stMemory)) && !busCyc;
    assign busDone  = busCyc && wbRsp.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= stFetch;
            pc     <= resetAddr;
            busCyc <= 1'b0;
            busWe  <= 1'b0;
        end else begin
            if (busStart) begin
                busCyc <= 1'b1;
                busWe  <= (state == stMemory) && ctrl.memWrite;
            end else if (busDone) begin
                busCyc <= 1'b0; // low for at least one cycle after ack.
                busWe  <= 1'b0;
            end

            case (state)
                stFetch: begin
                    if (busDone) begin
                        state <= stExecute;
                    end
                end
                stExecute: begin
                    if (ctrl.memRead || ctrl.memWrite) begin
                        state <= stMemory;
                    end else if (ctrl.regWrite) begin
                        state <= stWriteBack;
                    end else begin
                        pc    <= nextPc; // branches, j, jr and nops end here.
                        state <= stFetch;
                    end
                end
                stMemory: begin
                    if (busDone) begin
                        if (ctrl.memRead) begin
                            state <= stWriteBack;
                        end else begin
                            pc    <= nextPc;
                            state <= stFetch;
                        end
                    end
                end
                stWriteBack: begin
                    pc    <= nextPc;
                    state <= stFetch;
                end
                default: state <= stFetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (busStart) begin
            busAdr  <= (state == stMemory) ? aluOut : pc;
            busDatW <= rDataB; // store data from rt.
        end
        if ((state == stFetch) && busDone) begin
            instrReg <= wbRsp.datR;
        end
        if ((state == stMemory) && busDone) begin
            loadData <= wbRsp.datR;
        end
        if (state == stExecute) begin
            aluOut <= aluResult;
        end
    end

    // word accesses only.
    assign wbReq = '{
        cyc:  busCyc,
        stb:  busCyc,
        we:   busWe,
        sel:  4'hf,
        adr:  busAdr,
        datW: busDatW
    };

endmodule

`default_nettype wire

/* verif/tbMipsCore.sv */
`timescale 1ns/1ns
`default_nettype none

module tbMipsCore;

    localparam logic [31:0] resetAddr = 32'h0000_0100;
    localparam int memWords = 1024;

    logic         clk = 1'b0;
    logic         reset = 1'b1;
    logic         rspAck = 1'b0;
    logic [31:0]  rspDat = 32'd0;
    wbPkg::wbReqT wbReq;
    wbPkg::wbRspT wbRsp;
    wbPkg::wbReqT lastReq;

    logic [31:0]  mem [memWords];
    logic [63:0]  expStores [$]; // {address, data} in program order.
    logic [63:0]  expPair;
    logic [31:0]  storePtr = 32'h0000_0800;
    logic [31:0]  seed;
    int unsigned  waitLeft = 0;
    int           wp;
    int           progLen = 0;
    int           checks = 0;
    int           errors = 0;
    int           seen = 0;
    logic         resetSeen = 1'b0;
    logic         firstReq = 1'b0;
    logic         stalled = 1'b0;

    assign wbRsp = '{ack: rspAck, datR: rspDat};

    mipsCore #(
        .resetAddr (resetAddr)
    ) i_dut (
        .clk   (clk),
        .reset (reset),
        .wbReq (wbReq),
        .wbRsp (wbRsp)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] rWord(isaPkg::functE fn, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd, logic [4:0] sh);
        return {isaPkg::opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iWord(isaPkg::opcodeE op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jWord(isaPkg::opcodeE op, logic [25:0] target);
        return {op, target};
    endfunction

    task automatic putWord(logic [31:0] w);
        mem[wp] = w;
        wp++;
    endtask

    // store addresses double as path markers.
    task automatic storeReg(logic [4:0] rt);
        putWord(iWord(isaPkg::opSw, 5'd0, rt, storePtr[15:0]));
        storePtr += 32'd4;
    endtask

    task automatic aluStore(isaPkg::functE fn, logic [4:0] rs, logic [4:0] rt, logic [4:0] sh);
        putWord(rWord(fn, rs, rt, 5'd10, sh));
        storeReg(5'd10);
    endtask

    task automatic immStore(isaPkg::opcodeE op, logic [4:0] rs, logic [15:0] imm);
        putWord(iWord(op, rs, 5'd10, imm));
        storeReg(5'd10);
    endtask

    task automatic loadProgram();
        logic [31:0] rtAddr;
        wp = resetAddr[11:2];
        putWord(iWord(isaPkg::opLui, 5'd0, 5'd1, 16'd0));
        putWord(iWord(isaPkg::opOri, 5'd1, 5'd1, 16'd0));
        putWord(iWord(isaPkg::opLui, 5'd0, 5'd2, 16'd0));
        putWord(iWord(isaPkg::opOri, 5'd2, 5'd2, 16'd0));
        putWord(iWord(isaPkg::opAddi, 5'd0, 5'd3, 16'd0));
        putWord(iWord(isaPkg::opXori, 5'd3, 5'd4, 16'd0));
        putWord(rWord(isaPkg::fnSltu, 5'd0, 5'd1, 5'd9, 5'd0)); // r9 = 1.
        putWord(rWord(isaPkg::fnSll, 5'd0, 5'd9, 5'd11, 5'd31));
        putWord(rWord(isaPkg::fnOr, 5'd1, 5'd11, 5'd6, 5'd0)); // r6 always negative.
        aluStore(isaPkg::fnAdd, 5'd1, 5'd2, 5'd0);
        aluStore(isaPkg::fnSub, 5'd1, 5'd2, 5'd0);
        aluStore(isaPkg::fnAnd, 5'd1, 5'd2, 5'd0);
        aluStore(isaPkg::fnOr, 5'd1, 5'd2, 5'd0);
        aluStore(isaPkg::fnXor, 5'd1, 5'd2, 5'd0);
        aluStore(isaPkg::fnSll, 5'd0, 5'd2, 5'd7);
        aluStore(isaPkg::fnSlt, 5'd1, 5'd2, 5'd0);
        aluStore(isaPkg::fnSltu, 5'd1, 5'd2, 5'd0);
        aluStore(isaPkg::fnSlt, 5'd6, 5'd9, 5'd0);
        aluStore(isaPkg::fnSltu, 5'd6, 5'd9, 5'd0);
        aluStore(isaPkg::fnSlt, 5'd3, 5'd4, 5'd0);
        immStore(isaPkg::opAddi, 5'd1, 16'd0);
        immStore(isaPkg::opAddi, 5'd4, 16'd0);
        immStore(isaPkg::opAndi, 5'd1, 16'h8f0f);
        immStore(isaPkg::opOri, 5'd2, 16'd0);
        immStore(isaPkg::opXori, 5'd2, 16'd0);
        immStore(isaPkg::opLui, 5'd0, 16'd0);
        putWord(iWord(isaPkg::opAddi, 5'd1, 5'd0, 16'd0)); // write to $zero.
        storeReg(5'd0);
        rtAddr = storePtr;
        storeReg(5'd1);
        putWord(iWord(isaPkg::opLw, 5'd0, 5'd20, rtAddr[15:0]));
        storeReg(5'd20);
        // each branch skips one store when taken.
        putWord(iWord(isaPkg::opBeq, 5'd0, 5'd0, 16'd1));
        storeReg(5'd1);
        storeReg(5'd1);
        putWord(iWord(isaPkg::opBne, 5'd0, 5'd0, 16'd1));
        storeReg(5'd1);
        storeReg(5'd1);
        putWord(iWord(isaPkg::opBne, 5'd1, 5'd0, 16'd1));
        storeReg(5'd1);
        storeReg(5'd1);
        putWord(iWord(isaPkg::opBeq, 5'd6, 5'd0, 16'd1));
        storeReg(5'd6);
        storeReg(5'd6);
        putWord(jWord(isaPkg::opJ, 26'(wp + 2)));
        storeReg(5'd1);
        storeReg(5'd1);
        putWord(jWord(isaPkg::opJal, 26'(wp + 3)));
        storeReg(5'd2);
        putWord(jWord(isaPkg::opJ, 26'(wp + 3)));
        storeReg(5'd31); // subroutine stores its link.
        putWord(rWord(isaPkg::fnJr, 5'd31, 5'd0, 5'd0, 5'd0));
        putWord(jWord(isaPkg::opJ, 26'(wp)));
    endtask

    task automatic patchImmediates();
        logic [31:0] r;
        for (int i = resetAddr[11:2]; i < wp; i++) begin
            r = $urandom;
            if (mem[i][31:26] inside {isaPkg::opAddi, isaPkg::opOri, isaPkg::opXori,
                                      isaPkg::opLui}) begin
                mem[i][15:0] = r[15:0];
            end
        end
    endtask

    // interprets the program image and lists the stores it makes.
    function automatic void runReference();
        logic [31:0] rf [32];
        logic [31:0] dm [memWords];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] adr;
        logic [31:0] nxt;
        logic [31:0] jTarget;
        logic [4:0]  rd;
        logic        halt;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            rf[i] = 32'd0;
        end
        for (int i = 0; i < memWords; i++) begin
            dm[i] = mem[i];
        end
        pc = resetAddr;
        halt = 1'b0;
        steps = 0;
        while (!halt && steps < 100000) begin
            ins = dm[pc[11:2]];
            a = rf[ins[25:21]];
            b = rf[ins[20:16]];
            rd = ins[15:11];
            sImm = {{16{ins[15]}}, ins[15:0]};
            adr = a + sImm;
            nxt = pc + 32'd4;
            jTarget = {nxt[31:28], ins[25:0], 2'b00};
            case (ins[31:26])
                isaPkg::opSpecial: begin
                    case (ins[5:0])
                        isaPkg::fnAdd:  rf[rd] = a + b;
                        isaPkg::fnSub:  rf[rd] = a - b;
                        isaPkg::fnAnd:  rf[rd] = a & b;
                        isaPkg::fnOr:   rf[rd] = a | b;
                        isaPkg::fnXor:  rf[rd] = a ^ b;
                        isaPkg::fnSll:  rf[rd] = b << ins[10:6];
                        isaPkg::fnSlt:  rf[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        isaPkg::fnSltu: rf[rd] = (a < b) ? 32'd1 : 32'd0;
                        isaPkg::fnJr:   nxt = a;
                        default: ;
                    endcase
                end
                isaPkg::opAddi: rf[ins[20:16]] = a + sImm;
                isaPkg::opAndi: rf[ins[20:16]] = a & {16'h0000, ins[15:0]};
                isaPkg::opOri:  rf[ins[20:16]] = a | {16'h0000, ins[15:0]};
                isaPkg::opXori: rf[ins[20:16]] = a ^ {16'h0000, ins[15:0]};
                isaPkg::opLui:  rf[ins[20:16]] = {ins[15:0], 16'h0000};
                isaPkg::opLw:   rf[ins[20:16]] = dm[adr[11:2]];
                isaPkg::opSw: begin
                    dm[adr[11:2]] = b;
                    expStores.push_back({adr, b});
                end
                isaPkg::opBeq:  nxt = (a == b) ? nxt + (sImm << 2) : nxt;
                isaPkg::opBne:  nxt = (a != b) ? nxt + (sImm << 2) : nxt;
                isaPkg::opJ: begin
                    halt = (jTarget == pc); // jump to itself ends the program.
                    nxt = jTarget;
                end
                isaPkg::opJal: begin
                    rf[31] = nxt;
                    nxt = jTarget;
                end
                default: ;
            endcase
            rf[0] = 32'd0;
            pc = nxt;
            steps++;
        end
    endfunction

    task automatic finishRun();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        seed = $urandom(32'h62f8406e);
        for (int i = 0; i < memWords; i++) begin
            mem[i] = 32'hc0de_0000 | i;
        end
        loadProgram();
        patchImmediates();
        waitLeft = $urandom % 4;
        runReference();
        progLen = wp - resetAddr[11:2];
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

    // memory slave, 0 to 3 wait cycles per transfer.
    always @(posedge clk) begin
        if (reset) begin
            rspAck <= 1'b0;
        end else if (wbReq.cyc && wbReq.stb && !rspAck) begin
            if (waitLeft == 0) begin
                rspAck <= 1'b1;
                if (wbReq.we) begin
                    mem[wbReq.adr[11:2]] <= wbReq.datW;
                end else begin
                    rspDat <= mem[wbReq.adr[11:2]];
                end
                waitLeft <= $urandom % 4;
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end else begin
            rspAck <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            if (resetSeen && (wbReq.cyc !== 1'b0 || wbReq.stb !== 1'b0 || wbReq.we !== 1'b0)) begin
                $display("ERROR at %0t: bus not idle during reset", $time);
                errors++;
            end
            resetSeen = 1'b1;
        end else if (!firstReq) begin
            checks++;
            if (wbReq.cyc === 1'b1) begin
                firstReq = 1'b1;
                if (wbReq.adr !== resetAddr || wbReq.we !== 1'b0 || wbReq.stb !== 1'b1) begin
                    $display("ERROR at %0t: first request adr %h we %b, expected fetch of %h",
                             $time, wbReq.adr, wbReq.we, resetAddr);
                    errors++;
                end
            end else if (wbReq.stb !== 1'b0 || wbReq.we !== 1'b0 || wbReq.cyc !== 1'b0) begin
                $display("ERROR at %0t: bus not idle before first fetch", $time);
                errors++;
            end
        end
    end

    // requests are word wide and must hold until ack.
    always @(posedge clk) begin
        if (!reset && wbReq.cyc) begin
            if (rspAck) begin
                checks++;
                if (wbReq.sel !== 4'hf) begin
                    $display("ERROR at %0t: sel %h on a word access, expected f", $time,
                             wbReq.sel);
                    errors++;
                end
            end
            if (stalled && wbReq !== lastReq) begin
                $display("ERROR at %0t: request changed while ack low", $time);
                errors++;
            end
            stalled = !rspAck;
            lastReq = wbReq;
        end else begin
            stalled = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!reset && wbReq.cyc && wbReq.stb && wbReq.we && rspAck && expStores.size() > 0) begin
            checks++;
            seen++;
            expPair = expStores.pop_front();
            if (wbReq.adr !== expPair[63:32] || wbReq.datW !== expPair[31:0]) begin
                $display("ERROR at %0t: store expected %h <= %h, seen %h <= %h", $time,
                         expPair[63:32], expPair[31:0], wbReq.adr, wbReq.datW);
                errors++;
            end
            if (expStores.size() == 0) begin
                finishRun();
            end
        end
    end

    initial begin
        wait (progLen > 0);
        repeat (progLen * 40 + 5) @(posedge clk);
        $display("stores stopped early: %0d of %0d expected stores seen", seen,
                 seen + expStores.size());
        errors++;
        finishRun();
    end

endmodule

`default_nettype wire

/* src.f */
hdl/isaPkg.sv
hdl/wbPkg.sv
hdl/controller.sv
hdl/alu.sv
hdl/regFile.sv
hdl/mipsCore.sv
verif/tbMipsCore.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - hdl/isaPkg.sv
  - hdl/wbPkg.sv
  - hdl/controller.sv
  - hdl/alu.sv
  - hdl/regFile.sv
  - hdl/mipsCore.sv
  - target: simulation
    files:
      - verif/tbMipsCore.sv
